// File: hdl/cache_controller.sv
// Cache controller
// FSM that runs lookups, line fills from the fill FIFO and
// write-through stores, and answers the CPU with strobes
`timescale 1ns/1ps
`default_nettype none
`include "cache_params.svh"

module cache_controller
  import cache_pkg::*, mem_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req_valid,
  input  cpu_req_t                 req,
  input  logic                     hit,
  input  logic                     hit_way,
  input  logic [`CACHE_DATA_W-1:0] rdata,
  input  logic                     victim_way,
  input  logic                     fifo_empty,
  input  fill_word_t               fifo_data,
  output logic                     busy,
  output logic                     resp_valid,
  output cpu_resp_t                resp,
  output logic                     wr_done,
  output logic [`CACHE_ADDR_W-1:0] lookup_addr,
  output logic                     touch,
  output logic                     wr_we,
  output logic [`CACHE_DATA_W-1:0] wr_data,
  output logic                     fill_we,
  output logic                     fill_way,
  output fill_word_t               fill_word,
  output logic                     tag_we,
  output logic [`CACHE_TAG_W-1:0]  tag_in,
  output logic                     fifo_pop,
  output logic                     mem_cmd_valid,
  output mem_cmd_t                 mem_cmd
);

  ctrl_state_e              state, state_nxt;
  cpu_req_t                 req_q;
  logic                     hit_q;       // Hit flag seen in LOOKUP, reported to the CPU
  logic                     fill_way_q;  // Victim chosen for the current fill
  logic [`CACHE_WORD_W-1:0] fill_cnt;
  logic                     accept;
  logic                     last_word;

  // RESPOND and WRITE_THRU are the closing cycles and already take a new request
  assign busy      = (state == LOOKUP) || (state == MEM_REQ) || (state == FILL);
  assign accept    = req_valid && !busy;
  assign last_word = fifo_pop && (fill_cnt == '1);

  //////////////////////////////
  // State sequencing
  //////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE, RESPOND, WRITE_THRU: state_nxt = accept ? LOOKUP : IDLE;
      LOOKUP: begin
        if (req_q.write) state_nxt = WRITE_THRU; // Memory takes every store
        else if (hit)    state_nxt = RESPOND;
        else             state_nxt = MEM_REQ;
      end
      MEM_REQ: state_nxt = FILL;
      FILL:    if (last_word) state_nxt = RESPOND;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      fill_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (state == MEM_REQ) fill_cnt <= '0;
      else if (fifo_pop)    fill_cnt <= fill_cnt + 1'b1; // Words arrive in line order
    end
  end

  always_ff @(posedge clk) begin
    if (accept)            req_q      <= req;
    if (state == LOOKUP)   hit_q      <= hit;
    if (state == MEM_REQ)  fill_way_q <= victim_way; // Held steady for the whole burst
  end

  //////////////////////////////
  // Core and FIFO controls
  //////////////////////////////
  assign lookup_addr = req_q.addr;
  assign touch       = (state == LOOKUP) && hit;
  assign wr_we       = (state == WRITE_THRU) && hit_q;
  assign wr_data     = req_q.wdata;
  assign fifo_pop    = (state == FILL) && !fifo_empty;
  assign fill_we     = fifo_pop;
  assign fill_way    = fill_way_q;
  assign fill_word   = fifo_data;
  assign tag_we      = last_word;  // Tag goes valid together with the last word
  assign tag_in      = req_q.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

  // Read data comes straight from the core in RESPOND
  assign resp_valid = (state == RESPOND);
  assign wr_done    = (state == WRITE_THRU);
  assign resp       = '{rdata: rdata, hit: hit_q};

  // Line reads are aligned to word 0 of the line
  assign mem_cmd_valid = (state == MEM_REQ) || (state == WRITE_THRU);
  always_comb begin
    mem_cmd.wdata = req_q.wdata;
    if (state == WRITE_THRU) begin
      mem_cmd.op   = MEM_WRITE_WORD;
      mem_cmd.addr = req_q.addr[`CACHE_ADDR_W-1:1];
    end else begin
      mem_cmd.op   = MEM_READ_LINE;
      mem_cmd.addr = {req_q.addr[`CACHE_ADDR_W-1:`CACHE_WORD_W+1], `CACHE_WORD_W'(0)};
    end
  end

  // The CPU side has no handshake, so a request while busy would be lost
  assert property (@(posedge clk) disable iff (rst) req_valid |-> !busy)
    else $error("cache_controller: request while busy");

  // Fill words only show up while a line fill drains them
  assert property (@(posedge clk) disable iff (rst) !fifo_empty |-> (state == FILL))
    else $error("cache_controller: fill word outside a line fill");

  // After a fill the requested line sits in the way picked as victim
  assert property (@(posedge clk) disable iff (rst)
                   (state == RESPOND && !hit_q) |-> (hit && hit_way == fill_way_q))
    else $error("cache_controller: filled line not found in way %0d", fill_way_q);

endmodule

`default_nettype wire

// File: hdl/cache_core.sv
// Cache core
// Two-way tag and data arrays with parallel tag compare, one LRU bit
// per set, victim selection and write ports for fills and store hits
`timescale 1ns/1ps
`default_nettype none
`include "cache_params.svh"

module cache_core
  import cache_pkg::*, mem_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`CACHE_ADDR_W-1:0] lookup_addr,
  input  logic                     fill_we,     // Write one fill word into fill_way
  input  logic                     fill_way,
  input  fill_word_t               fill_word,
  input  logic                     tag_we,      // Line complete, mark fill_way valid
  input  logic [`CACHE_TAG_W-1:0]  tag_in,
  input  logic                     wr_we,       // Store hit, update the hit way
  input  logic [`CACHE_DATA_W-1:0] wr_data,
  input  logic                     touch,       // Access counts for LRU
  output logic                     hit,
  output logic                     hit_way,
  output logic [`CACHE_DATA_W-1:0] rdata,
  output logic                     victim_way
);

  tag_entry_t               tags [`CACHE_SETS][2];
  logic [`CACHE_SETS-1:0]   lru;  // Holds the least recently used way of each set
  logic [`CACHE_DATA_W-1:0] data [2][`CACHE_SETS][`CACHE_LINE_WORDS];

  logic [`CACHE_TAG_W-1:0]  addr_tag;
  logic [`CACHE_SET_W-1:0]  set_idx;
  logic [`CACHE_WORD_W-1:0] word_idx;
  logic [1:0]               way_hit;

  assign addr_tag = lookup_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
  assign set_idx  = lookup_addr[`CACHE_WORD_W+1 +: `CACHE_SET_W];
  assign word_idx = lookup_addr[1 +: `CACHE_WORD_W]; // Bit 0 is the byte within the word

  //////////////////////////////
  // Lookup
  //////////////////////////////
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = tags[set_idx][w].valid && (tags[set_idx][w].tag == addr_tag);
    end
  end

  assign hit     = |way_hit;
  assign hit_way = way_hit[1];
  assign rdata   = data[hit_way][set_idx][word_idx]; // Only meaningful with hit

  // An empty way is always filled before anything gets evicted
  assign victim_way = !tags[set_idx][0].valid ? 1'b0 :
                      !tags[set_idx][1].valid ? 1'b1 : lru[set_idx];

  //////////////////////////////
  // Tag and LRU update
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        tags[s][0] <= '0;
        tags[s][1] <= '0;
      end
      lru <= '0;
    end else if (tag_we) begin
      tags[set_idx][fill_way] <= '{tag: tag_in, valid: 1'b1};
      lru[set_idx]            <= ~fill_way; // New line is the most recent one
    end else if (touch && hit) begin
      lru[set_idx] <= ~hit_way;
    end
  end

  // Data words, fills and store hits never overlap in time
  always_ff @(posedge clk) begin
    if (fill_we) begin
      data[fill_way][set_idx][fill_word.idx] <= fill_word.data;
    end else if (wr_we) begin
      data[hit_way][set_idx][word_idx] <= wr_data;
    end
  end

  // A line lives in one way only, so a fill never duplicates a resident tag
  assert property (@(posedge clk) disable iff (rst) !(way_hit[0] && way_hit[1]))
    else $error("cache_core: tag hit in both ways of set %0d", set_idx);

endmodule

`default_nettype wire

// File: hdl/cache_params.svh
// Cache subsystem parameters
// Address split, line geometry, memory latency and fill FIFO depth
// for the 2 KB two-way cache and its backing memory
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

//////////////////////////////
// Address fields
//////////////////////////////
`define CACHE_ADDR_W     16 // Byte address from the CPU
`define CACHE_TAG_W      6  // addr[15:10]
`define CACHE_SET_W      6  // addr[9:4]
`define CACHE_WORD_W     3  // addr[3:1], word within the line

// Line geometry
`define CACHE_DATA_W     16
`define CACHE_LINE_WORDS 8
`define CACHE_SETS       64

//////////////////////////////
// Memory side
//////////////////////////////
`define MEM_ADDR_W       15 // Word address, 32K words
`define MEM_LATENCY      4  // Cycles from line read command to first word
`define FILL_FIFO_DEPTH  4

`endif

// File: hdl/cache_pkg.sv
// Cache side types
// Tag entries, CPU request and response, and controller states
`default_nettype none

package cache_pkg;

  `include "cache_params.svh"

  // One way of one set in the tag array
  typedef struct packed {
    logic [`CACHE_TAG_W-1:0] tag;
    logic                    valid;
  } tag_entry_t;

  // CPU request, registered by the controller on req_valid
  typedef struct packed {
    logic                     write;  // High for a store
    logic [`CACHE_ADDR_W-1:0] addr;   // Byte address, bit 0 ignored
    logic [`CACHE_DATA_W-1:0] wdata;
  } cpu_req_t;

  // Response to the CPU
  typedef struct packed {
    logic [`CACHE_DATA_W-1:0] rdata;
    logic                     hit;    // Line was already present on arrival
  } cpu_resp_t;

  // Controller FSM states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,     // Tags compared against the registered request
    MEM_REQ,    // Line read command sent to memory
    FILL,       // Fill words drained from the FIFO into the data array
    RESPOND,    // Read data returned
    WRITE_THRU  // Store sent to memory, cache updated on a hit
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: hdl/cache_subsystem.sv
// Cache subsystem top
// Controller, two-way cache core, fill FIFO and main memory
`timescale 1ns/1ps
`default_nettype none
`include "cache_params.svh"

module cache_subsystem
  import cache_pkg::*, mem_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      req_valid,
  input  cpu_req_t  req,
  output logic      busy,
  output logic      resp_valid,
  output cpu_resp_t resp,
  output logic      wr_done
);

  // Controller to core
  logic [`CACHE_ADDR_W-1:0] lookup_addr;
  logic                     hit, hit_way, victim_way, touch;
  logic [`CACHE_DATA_W-1:0] rdata, wr_data;
  logic                     wr_we, fill_we, fill_way, tag_we;
  fill_word_t               fill_word;
  logic [`CACHE_TAG_W-1:0]  tag_in;

  // FIFO and memory
  logic       fifo_pop, fifo_empty, fifo_full;
  fill_word_t fifo_data;
  logic       mem_cmd_valid, mem_push;
  mem_cmd_t   mem_cmd;
  fill_word_t mem_push_data;

  cache_controller u_ctrl (
    .clk, .rst, .req_valid, .req, .hit, .hit_way, .rdata, .victim_way,
    .fifo_empty, .fifo_data, .busy, .resp_valid, .resp, .wr_done,
    .lookup_addr, .touch, .wr_we, .wr_data, .fill_we, .fill_way, .fill_word,
    .tag_we, .tag_in, .fifo_pop, .mem_cmd_valid, .mem_cmd
  );

  cache_core u_core (
    .clk, .rst, .lookup_addr, .fill_we, .fill_way, .fill_word, .tag_we, .tag_in,
    .wr_we, .wr_data, .touch, .hit, .hit_way, .rdata, .victim_way
  );

  fill_fifo u_fifo (
    .clk, .rst, .push(mem_push), .push_data(mem_push_data), .pop(fifo_pop),
    .pop_data(fifo_data), .empty(fifo_empty), .full(fifo_full)
  );

  main_memory u_mem (
    .clk, .rst, .cmd_valid(mem_cmd_valid), .cmd(mem_cmd), .fifo_full,
    .push(mem_push), .push_data(mem_push_data)
  );

endmodule

`default_nettype wire

// File: hdl/fill_fifo.sv
// Fill FIFO
// Circular buffer of fill words between the memory burst and the
// cache core, with show-ahead output and a full flag for back-pressure
`timescale 1ns/1ps
`default_nettype none
`include "cache_params.svh"

module fill_fifo
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       push,
  input  fill_word_t push_data,
  input  logic       pop,
  output fill_word_t pop_data,
  output logic       empty,
  output logic       full
);

  localparam int AW = $clog2(`FILL_FIFO_DEPTH);

  fill_word_t  slots [`FILL_FIFO_DEPTH];
  logic [AW:0] wr_ptr, rd_ptr; // Extra bit tells full from empty

  assign empty    = (wr_ptr == rd_ptr);
  assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign pop_data = slots[rd_ptr[AW-1:0]]; // Head word visible before the pop

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push && !full) wr_ptr <= wr_ptr + 1'b1;
      if (pop && !empty) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push && !full) slots[wr_ptr[AW-1:0]] <= push_data;
  end

  // The memory must stall on full, otherwise a fill word disappears
  assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else $error("fill_fifo: push while full");

endmodule

`default_nettype wire

// File: hdl/main_memory.sv
// Main memory
// 32K word backing store. Word writes take one cycle; a line read
// waits a fixed latency and then streams eight words into the fill
// FIFO, holding the current word while the FIFO is full
`timescale 1ns/1ps
`default_nettype none
`include "cache_params.svh"

module main_memory
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       cmd_valid,
  input  mem_cmd_t   cmd,
  input  logic       fifo_full,
  output logic       push,
  output fill_word_t push_data
);

  localparam int LAT_W = $clog2(`MEM_LATENCY + 1);

  logic [`CACHE_DATA_W-1:0]              store [2**`MEM_ADDR_W];
  logic                                  active;    // Line burst in progress
  logic [LAT_W-1:0]                      lat_cnt;
  logic [`MEM_ADDR_W-`CACHE_WORD_W-1:0]  line_base; // Word address bits above the line
  logic [`CACHE_WORD_W-1:0]              word_cnt;

  // Contents are kept across reset
  always_ff @(posedge clk) begin
    if (cmd_valid && cmd.op == MEM_WRITE_WORD) store[cmd.addr] <= cmd.wdata;
  end

  //////////////////////////////
  // Line burst
  //////////////////////////////
  assign push      = active && (lat_cnt == '0) && !fifo_full;
  assign push_data = '{idx: word_cnt, data: store[{line_base, word_cnt}]};

  always_ff @(posedge clk) begin
    if (rst) begin
      active   <= 1'b0;
      lat_cnt  <= '0;
      word_cnt <= '0;
    end else if (cmd_valid && cmd.op == MEM_READ_LINE) begin
      active   <= 1'b1;
      lat_cnt  <= LAT_W'(`MEM_LATENCY - 1); // First word MEM_LATENCY cycles after the command
      word_cnt <= '0;
    end else if (active) begin
      if (lat_cnt != '0) begin
        lat_cnt <= lat_cnt - 1'b1;
      end else if (push) begin
        word_cnt <= word_cnt + 1'b1;
        if (word_cnt == '1) active <= 1'b0; // Eighth word accepted
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid && cmd.op == MEM_READ_LINE) begin
      line_base <= cmd.addr[`MEM_ADDR_W-1:`CACHE_WORD_W];
    end
  end

endmodule

`default_nettype wire

// File: hdl/mem_pkg.sv
// Memory side types
// Memory command, memory opcode and the fill word carried to the cache
`default_nettype none

package mem_pkg;

  `include "cache_params.svh"

  typedef enum logic {
    MEM_READ_LINE,  // Stream a whole line into the fill FIFO
    MEM_WRITE_WORD  // Single word store, done in one cycle
  } mem_op_e;

  // Command from the controller to the memory
  typedef struct packed {
    mem_op_e                op;
    logic [`MEM_ADDR_W-1:0] addr;   // Word address, line aligned for reads
    logic [`CACHE_DATA_W-1:0] wdata;
  } mem_cmd_t;

  // One word of a line burst, tagged with its slot in the line
  typedef struct packed {
    logic [`CACHE_WORD_W-1:0] idx;
    logic [`CACHE_DATA_W-1:0] data;
  } fill_word_t;

endpackage

`default_nettype wire

// File: list.f
+incdir+hdl
hdl/cache_pkg.sv
hdl/mem_pkg.sv
hdl/cache_core.sv
hdl/fill_fifo.sv
hdl/main_memory.sv
hdl/cache_controller.sv
hdl/cache_subsystem.sv
tests/cache_subsystem_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the cache subsystem testbench with Verilator, runs it into sim.log
# and decides the result from the log
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module cache_subsystem_tb \
  --Mdir obj_dir -o cache_sim

./obj_dir/cache_sim | tee sim.log

if grep -qx "TEST PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// File: tests/cache_subsystem_tb.sv
// Cache subsystem testbench
// Table-driven CPU requests checked against a reference model of the
// memory and of the tags, valid bits and LRU bit of every set
`timescale 1ns/1ps
`default_nettype none
`include "cache_params.svh"

module cache_subsystem_tb
  import cache_pkg::*;
();

  localparam int BUSY_TIMEOUT = 50;
  localparam int RESP_TIMEOUT = 200; // Covers memory latency plus an 8-word burst

  typedef enum logic [1:0] {T_READ, T_WRITE, T_RESET} tb_op_e;

  // One row of the stimulus table
  typedef struct packed {
    logic [3:0]               test;
    tb_op_e                   op;
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [`CACHE_DATA_W-1:0] wdata;
    logic                     exp_hit;
    logic                     use_model; // Expected hit flag comes from the reference model
  } stim_entry_t;

  logic      clk, rst, req_valid, busy, resp_valid, wr_done;
  cpu_req_t  req;
  cpu_resp_t resp;

  stim_entry_t stim [$];
  integer      seed;
  int          checks, errors, test_checks, test_errors;
  bit          timed_out;

  //////////////////////////////
  // Reference model state
  //////////////////////////////
  logic [`CACHE_DATA_W-1:0] ref_mem   [2**`MEM_ADDR_W];
  logic [`CACHE_TAG_W-1:0]  ref_tag   [`CACHE_SETS][2];
  logic                     ref_valid [`CACHE_SETS][2];
  logic                     ref_lru   [`CACHE_SETS]; // Way to evict when both are valid

  string test_name [1:6] = '{"write miss then read miss and hit", "write hit and write-through",
                             "LRU with three tags in one set", "reset invalidates lines",
                             "random reads and writes", "line fill word order"};

  cache_subsystem uut (.clk, .rst, .req_valid, .req, .busy, .resp_valid, .resp, .wr_done);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic add_entry(input logic [3:0] test, input tb_op_e op, input logic [5:0] tag,
                           input logic [5:0] set_i, input logic [2:0] word,
                           input logic [15:0] wdata, input logic exp_hit, input logic use_model);
    stim_entry_t e;
    e = '{test: test, op: op, addr: {tag, set_i, word, 1'b0}, wdata: wdata,
          exp_hit: exp_hit, use_model: use_model};
    stim.push_back(e);
  endtask

  task automatic build_table();
    logic [31:0] rv;
    logic [5:0]  pick;
    bit          written [64]; // Random pool words that memory already holds
    add_entry(4'd1, T_WRITE, 6'd1, 6'd3, 3'd2, 16'h1234, 1'b0, 1'b0); // No allocate on a miss
    add_entry(4'd1, T_READ,  6'd1, 6'd3, 3'd2, 16'h0,    1'b0, 1'b0);
    add_entry(4'd1, T_READ,  6'd1, 6'd3, 3'd2, 16'h0,    1'b1, 1'b0);
    add_entry(4'd2, T_WRITE, 6'd1, 6'd3, 3'd2, 16'hbeef, 1'b1, 1'b0);
    add_entry(4'd2, T_READ,  6'd1, 6'd3, 3'd2, 16'h0,    1'b1, 1'b0);
    add_entry(4'd2, T_WRITE, 6'd2, 6'd3, 3'd0, 16'h2222, 1'b0, 1'b0);
    add_entry(4'd2, T_WRITE, 6'd3, 6'd3, 3'd0, 16'h3333, 1'b0, 1'b0);
    add_entry(4'd2, T_READ,  6'd2, 6'd3, 3'd0, 16'h0,    1'b0, 1'b0); // Fills the empty way
    add_entry(4'd2, T_READ,  6'd3, 6'd3, 3'd0, 16'h0,    1'b0, 1'b0); // Evicts the 0xbeef line
    add_entry(4'd2, T_READ,  6'd1, 6'd3, 3'd2, 16'h0,    1'b0, 1'b0); // Memory must hold 0xbeef
    add_entry(4'd2, T_READ,  6'd1, 6'd3, 3'd2, 16'h0,    1'b1, 1'b0);
    // Tags 1, 2 and 3 as A, B and C in set 7
    add_entry(4'd3, T_WRITE, 6'd1, 6'd7, 3'd0, 16'haaaa, 1'b0, 1'b0);
    add_entry(4'd3, T_WRITE, 6'd2, 6'd7, 3'd0, 16'hbbbb, 1'b0, 1'b0);
    add_entry(4'd3, T_WRITE, 6'd3, 6'd7, 3'd0, 16'hcccc, 1'b0, 1'b0);
    add_entry(4'd3, T_READ,  6'd1, 6'd7, 3'd0, 16'h0,    1'b0, 1'b0);
    add_entry(4'd3, T_READ,  6'd2, 6'd7, 3'd0, 16'h0,    1'b0, 1'b0);
    add_entry(4'd3, T_READ,  6'd1, 6'd7, 3'd0, 16'h0,    1'b1, 1'b0); // Touch makes B the LRU way
    add_entry(4'd3, T_READ,  6'd3, 6'd7, 3'd0, 16'h0,    1'b0, 1'b0);
    add_entry(4'd3, T_READ,  6'd1, 6'd7, 3'd0, 16'h0,    1'b1, 1'b0);
    add_entry(4'd3, T_READ,  6'd2, 6'd7, 3'd0, 16'h0,    1'b0, 1'b0);
    add_entry(4'd4, T_READ,  6'd1, 6'd7, 3'd0, 16'h0,    1'b1, 1'b0);
    add_entry(4'd4, T_RESET, 6'd0, 6'd0, 3'd0, 16'h0,    1'b0, 1'b0);
    add_entry(4'd4, T_READ,  6'd1, 6'd7, 3'd0, 16'h0,    1'b0, 1'b0);
    add_entry(4'd4, T_READ,  6'd1, 6'd7, 3'd0, 16'h0,    1'b1, 1'b0);
    add_entry(4'd4, T_READ,  6'd2, 6'd7, 3'd0, 16'h0,    1'b0, 1'b0);
    // Four tags over sets 10 and 11, so the two ways keep getting evicted
    for (int k = 0; k < 64; k++) begin
      rv   = $random(seed);
      pick = rv[5:0];
      if (rv[8:7] != 2'b00 && written[pick]) begin
        add_entry(4'd5, T_READ, {4'd0, pick[5:4]}, {5'd5, pick[3]}, pick[2:0], 16'h0, 1'b0, 1'b1);
      end else begin
        add_entry(4'd5, T_WRITE, {4'd0, pick[5:4]}, {5'd5, pick[3]}, pick[2:0], rv[31:16],
                  1'b0, 1'b1);
        written[pick] = 1'b1;
      end
    end
    for (int w = 0; w < 8; w++) begin
      add_entry(4'd6, T_WRITE, 6'd5, 6'd20, w[2:0], {w[3:0], 4'hc, w[3:0], 4'h3}, 1'b0, 1'b0);
    end
    add_entry(4'd6, T_READ, 6'd5, 6'd20, 3'd5, 16'h0, 1'b0, 1'b0); // Miss in the middle of the line
    for (int w = 0; w < 8; w++) begin
      add_entry(4'd6, T_READ, 6'd5, 6'd20, w[2:0], 16'h0, 1'b1, 1'b0);
    end
  endtask

  // Reset invalidates the lines but keeps the memory words
  task automatic clear_model();
    foreach (ref_valid[s]) begin
      ref_valid[s][0] = 1'b0;
      ref_valid[s][1] = 1'b0;
      ref_lru[s]      = 1'b0;
    end
  endtask

  // Predicts hit and data, then updates the model as the access would
  task automatic predict_access(input cpu_req_t r, output logic hit, output logic [15:0] data);
    logic [5:0] tag, s;
    logic       way;
    tag = r.addr[15:10];
    s   = r.addr[9:4];
    hit = 1'b1;
    if (ref_valid[s][0] && ref_tag[s][0] == tag) way = 1'b0;
    else if (ref_valid[s][1] && ref_tag[s][1] == tag) way = 1'b1;
    else begin
      hit = 1'b0;
      way = !ref_valid[s][0] ? 1'b0 : !ref_valid[s][1] ? 1'b1 : ref_lru[s]; // Empty way first
    end
    if (r.write) ref_mem[r.addr[15:1]] = r.wdata; // Memory takes every write
    if (hit || !r.write) begin
      ref_tag[s][way]   = tag;
      ref_valid[s][way] = 1'b1;
      ref_lru[s]        = !way; // Accessed way becomes the most recent one
    end
    data = ref_mem[r.addr[15:1]];
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (busy && n < BUSY_TIMEOUT);
    if (busy) begin
      $display("Timed out at %0t waiting for busy to fall", $time);
      timed_out = 1'b1;
      errors++;
    end
  endtask

  task automatic pulse_reset();
    wait_idle();
    @(posedge clk);
    rst <= 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    clear_model();
  endtask

  task automatic check_resp(input cpu_resp_t got, input cpu_resp_t exp);
    checks++;
    if (got.rdata !== exp.rdata) begin
      $display("ERROR t=%0t resp.rdata: got %h expected %h", $time, got.rdata, exp.rdata);
      errors++;
    end
    if (got.hit !== exp.hit) begin
      $display("ERROR t=%0t resp.hit: got %b expected %b", $time, got.hit, exp.hit);
      errors++;
    end
  endtask

  task automatic check_hit(input cpu_resp_t got, input logic exp_hit);
    checks++;
    if (got.hit !== exp_hit) begin
      $display("ERROR t=%0t resp.hit: got %b expected %b", $time, got.hit, exp_hit);
      errors++;
    end
  endtask

  task automatic check_busy(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("ERROR t=%0t busy: got %b expected %b", $time, got, exp);
      errors++;
    end
  endtask

  //////////////////////////////
  // One request per table row
  //////////////////////////////
  task automatic apply_entry(input stim_entry_t e);
    cpu_req_t    r;
    cpu_resp_t   exp;
    logic        mhit;
    logic [15:0] mdata;
    int          n;
    if (e.op == T_RESET) begin
      pulse_reset();
      return;
    end
    r = '{write: (e.op == T_WRITE), addr: e.addr, wdata: e.wdata};
    predict_access(r, mhit, mdata);
    if (!e.use_model && e.exp_hit !== mhit) begin
      $display("Table row for address %h expects hit %b but the model predicts %b",
               e.addr, e.exp_hit, mhit);
      errors++;
    end
    exp = '{rdata: mdata, hit: e.use_model ? mhit : e.exp_hit};
    wait_idle();
    if (timed_out) return;
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= r;
    @(posedge clk);
    req_valid <= 1'b0;
    n = 0; // Counts cycles after the req_valid cycle
    do begin
      @(negedge clk);
      n++;
      if (n == 1) check_busy(busy, 1'b1); // Request registered, busy is up
    end while (!(resp_valid || wr_done) && n < RESP_TIMEOUT);
    if (!(resp_valid || wr_done)) begin
      $display("Timed out at %0t waiting for a response to address %h", $time, r.addr);
      timed_out = 1'b1;
      errors++;
      return;
    end
    if (wr_done != r.write || resp_valid == r.write) begin
      $display("Wrong strobe at %0t for address %h, a %s got the other kind of answer",
               $time, r.addr, r.write ? "write" : "read");
      errors++;
    end
    check_busy(busy, 1'b0); // Busy drops together with the strobe
    if (r.write) check_hit(resp, exp.hit);
    else check_resp(resp, exp);
    if ((r.write || exp.hit) && n != 2) begin // Hits and writes have a fixed latency
      $display("ERROR t=%0t response latency: got %0d expected 2", $time, n);
      errors++;
    end
  endtask

  task automatic report_test(input int t);
    $display("test %0d (%s): %0d checks, %0d errors", t, test_name[t],
             checks - test_checks, errors - test_errors);
    test_checks = checks;
    test_errors = errors;
  endtask

  initial begin
    int cur;
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    seed      = 32'hdb0b0818;
    clear_model();
    build_table();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    cur = int'(stim[0].test);
    foreach (stim[i]) begin
      if (int'(stim[i].test) != cur) begin
        report_test(cur);
        cur = int'(stim[i].test);
      end
      if (!timed_out) apply_entry(stim[i]); // After a timeout the rest is skipped
    end
    report_test(cur);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
